// File: src.f
common/vga_pkg.sv
common/geom_pkg.sv
verilog/fillscreen.sv
circle/circle.sv
reuleaux/reuleaux_fsm.sv
reuleaux/reuleaux.sv
test/tb_reuleaux.sv

// File: test/tb_reuleaux.sv
`timescale 1ns/1ps

module tb_reuleaux;

    localparam int SCREEN_W = 160;
    localparam int SCREEN_H = 120;
    localparam int WAIT_LIMIT = 100000;

    logic             clk;
    logic             rst_n;
    logic             start;
    vga_pkg::colour_t colour;
    vga_pkg::x_t      centre_x;
    vga_pkg::y_t      centre_y;
    vga_pkg::x_t      diameter;
    logic             done;
    vga_pkg::x_t      vga_x;
    vga_pkg::y_t      vga_y;
    vga_pkg::colour_t vga_colour;
    logic             vga_plot;

    int     monitor_errors = 0;
    int     test_errors = 0;
    integer seed = 32'hb437;

    // Expected colour and corner coordinates of the current drawing
    vga_pkg::colour_t exp_colour;
    int exp_cx, exp_d, exp_x1, exp_x2, exp_x3, exp_y1, exp_y3;

    // Shadow screen and clear bookkeeping
    vga_pkg::colour_t shadow [SCREEN_W][SCREEN_H];
    int               fill_cnt [SCREEN_W][SCREEN_H];
    int               fill_total;
    bit               arcs_seen;

    reuleaux #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) u_reuleaux (
        .clk(clk), .rst_n(rst_n), .colour(colour), .centre_x(centre_x),
        .centre_y(centre_y), .diameter(diameter), .start(start), .done(done),
        .vga_x(vga_x), .vga_y(vga_y), .vga_colour(vga_colour), .vga_plot(vga_plot)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Pixel monitor sampling mid-cycle
    always @(negedge clk) begin
        if (rst_n === 1'b1 && vga_plot === 1'b1) begin
            assert (vga_x < SCREEN_W) else begin
                $display("FAILED vga_x: 0x%h, screen width 0x%h", vga_x, SCREEN_W);
                monitor_errors++;
            end
            assert (vga_y < SCREEN_H) else begin
                $display("FAILED vga_y: 0x%h, screen height 0x%h", vga_y, SCREEN_H);
                monitor_errors++;
            end
            if (vga_x < SCREEN_W && vga_y < SCREEN_H) begin
                if (vga_colour == vga_pkg::COLOUR_BLACK) begin
                    assert (!arcs_seen) else begin
                        $display("Black pixel written after the arcs had started");
                        monitor_errors++;
                    end
                    fill_cnt[vga_x][vga_y]++;
                    fill_total++;
                end else begin
                    assert (vga_colour == exp_colour) else begin
                        $display("FAILED vga_colour: 0x%h, expected 0x%h", vga_colour, exp_colour);
                        monitor_errors++;
                    end
                    arcs_seen = 1'b1;
                end
                shadow[vga_x][vga_y] = vga_colour;
            end
        end
    end

    function automatic bit near_circle(int px, int py, int ccx, int ccy, int d);
        int err;
        err = (px - ccx) * (px - ccx) + (py - ccy) * (py - ccy) - d * d;
        return (err <= 2 * d) && (err >= -2 * d);
    endfunction

    function automatic bit on_arc(int px, int py);
        bit ok;
        ok = 1'b0;
        if (near_circle(px, py, exp_x1, exp_y1, exp_d) && px >= exp_x2 && px <= exp_x3 &&
            py <= exp_y1) ok = 1'b1;
        if (near_circle(px, py, exp_x2, exp_y1, exp_d) && px >= exp_x3 && px <= exp_x1 &&
            py <= exp_y1) ok = 1'b1;
        if (near_circle(px, py, exp_x3, exp_y3, exp_d) && px >= exp_x2 && px <= exp_x1 &&
            py >= exp_y1) ok = 1'b1;
        return ok;
    endfunction

    task automatic wait_for_done(input logic level, input int limit, output bit ok);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (done !== level && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        ok = (done === level);
        assert (ok) else begin
            $display("Timeout: done did not reach %0d within %0d cycles", level, limit);
            test_errors++;
        end
    endtask

    task automatic run_drawing(input vga_pkg::colour_t col, input int cx, cy, d);
        bit ok;
        for (int x = 0; x < SCREEN_W; x++) begin
            for (int y = 0; y < SCREEN_H; y++) begin
                shadow[x][y]   = vga_pkg::COLOUR_BLACK;
                fill_cnt[x][y] = 0;
            end
        end
        fill_total = 0;
        arcs_seen  = 1'b0;
        exp_colour = col;
        exp_cx = cx;
        exp_d  = d;
        exp_x1 = cx + d / 2;
        exp_x2 = cx - d / 2;
        exp_x3 = cx;
        exp_y1 = cy + ((d * geom_pkg::SQRT3_DIV6) >> geom_pkg::FRAC_BITS);
        exp_y3 = cy - ((d * geom_pkg::SQRT3_DIV3) >> geom_pkg::FRAC_BITS);
        @(posedge clk);
        colour   <= col;
        centre_x <= vga_pkg::x_t'(cx);
        centre_y <= vga_pkg::y_t'(cy);
        diameter <= vga_pkg::x_t'(d);
        start    <= 1'b1;
        wait_for_done(1'b1, WAIT_LIMIT, ok);
        // done holds while start stays high
        for (int i = 0; i < 3 && ok; i++) begin
            @(negedge clk);
            assert (done === 1'b1) else begin
                $display("FAILED done: 0x%h, expected 0x1 while start is high", done);
                test_errors++;
            end
        end
        @(posedge clk);
        start <= 1'b0;
        wait_for_done(1'b0, 1, ok);
    endtask

    task automatic check_clear();
        int bad;
        bad = 0;
        for (int x = 0; x < SCREEN_W; x++) begin
            for (int y = 0; y < SCREEN_H; y++) begin
                if (fill_cnt[x][y] != 1) bad++;
            end
        end
        assert (fill_total == SCREEN_W * SCREEN_H) else begin
            $display("FAILED fill_total: 0x%h, expected 0x%h", fill_total, SCREEN_W * SCREEN_H);
            test_errors++;
        end
        assert (bad == 0) else begin
            $display("%0d pixels were not cleared exactly once", bad);
            test_errors++;
        end
    endtask

    task automatic check_arcs(input int min_pixels, input bit mirror);
        int coloured, off_arc, asym, mx;
        coloured = 0;
        off_arc  = 0;
        asym     = 0;
        for (int x = 0; x < SCREEN_W; x++) begin
            for (int y = 0; y < SCREEN_H; y++) begin
                if (shadow[x][y] != vga_pkg::COLOUR_BLACK) begin
                    coloured++;
                    if (!on_arc(x, y)) off_arc++;
                    // Mirror image about the centre column with one pixel of slack
                    mx = 2 * exp_cx - x;
                    if (mirror && mx >= 1 && mx < SCREEN_W - 1 &&
                        shadow[mx-1][y] == 0 && shadow[mx][y] == 0 && shadow[mx+1][y] == 0)
                        asym++;
                end
            end
        end
        assert (off_arc == 0) else begin
            $display("%0d coloured pixels lie off the expected arcs", off_arc);
            test_errors++;
        end
        if (mirror) begin
            assert (asym == 0) else begin
                $display("%0d coloured pixels have no mirror image", asym);
                test_errors++;
            end
        end
        assert (coloured >= min_pixels) else begin
            $display("Only %0d coloured pixels were drawn", coloured);
            test_errors++;
        end
    endtask

    task automatic test_reset();
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            assert (done === 1'b0 && vga_plot === 1'b0) else begin
                $display("FAILED done/vga_plot: 0x%h/0x%h, expected 0x0", done, vga_plot);
                test_errors++;
            end
        end
    endtask

    task automatic test_centred();
        run_drawing(3'h5, 80, 60, 80);
        check_clear();
        check_arcs(1, 1'b1);
    endtask

    task automatic test_clipping();
        run_drawing(3'h3, 5, 5, 100);
        check_clear();
        check_arcs(1, 1'b0);
    endtask

    task automatic test_restart();
        vga_pkg::colour_t col;
        int cx, cy, d;
        for (int i = 0; i < 2; i++) begin
            col = vga_pkg::colour_t'($random(seed));
            if (col == vga_pkg::COLOUR_BLACK) col = 3'h7;
            // Ranges keep every corner inside the signed coordinate types
            cx = 40 + ($unsigned($random(seed)) % 80);
            cy = 30 + ($unsigned($random(seed)) % 60);
            d  = 20 + ($unsigned($random(seed)) % 80);
            $display("Restart %0d: colour %0d centre (%0d,%0d) diameter %0d", i, col, cx, cy, d);
            run_drawing(col, cx, cy, d);
            check_clear();
            check_arcs(1, 1'b0);
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        start    = 1'b0;
        colour   = '0;
        centre_x = '0;
        centre_y = '0;
        diameter = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_centred();
        test_clipping();
        test_restart();
        $display("Errors: monitor %0d, tests %0d", monitor_errors, test_errors);
        if (monitor_errors + test_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: reuleaux/reuleaux.sv
`timescale 1ns/1ps

// Reuleaux triangle drawer on a pixel-write port
module reuleaux #(
    parameter int SCREEN_W = 160,
    parameter int SCREEN_H = 120
) (
    input  logic             clk,
    input  logic             rst_n,
    input  vga_pkg::colour_t colour,
    input  vga_pkg::x_t      centre_x,
    input  vga_pkg::y_t      centre_y,
    input  vga_pkg::x_t      diameter,
    input  logic             start,
    output logic             done,
    output vga_pkg::x_t      vga_x,
    output vga_pkg::y_t      vga_y,
    output vga_pkg::colour_t vga_colour,
    output logic             vga_plot
);

    // Sequencer controls
    logic       fill_start;
    logic       fill_done;
    logic       load_corners;
    logic       circle_start;
    logic       circle_done;
    logic       draw_arcs;
    logic [1:0] arc_sel;

    // Fill stream
    vga_pkg::x_t fill_x;
    vga_pkg::y_t fill_y;
    logic        fill_plot;

    // Circle stream
    vga_pkg::x_t circ_x;
    vga_pkg::y_t circ_y;
    logic        circ_plot;

    // Corner arithmetic
    geom_pkg::sx_t   cx_s;
    geom_pkg::sy_t   cy_s;
    geom_pkg::sx_t   d_s;
    geom_pkg::sx_t   half_d;
    geom_pkg::prod_t prod_side;
    geom_pkg::prod_t prod_top;
    geom_pkg::sx_t   x1_c;
    geom_pkg::sx_t   x2_c;
    geom_pkg::sx_t   x3_c;
    geom_pkg::sy_t   y12_c;
    geom_pkg::sy_t   y3_c;

    // Held corners, corners 1 and 2 share a row
    geom_pkg::sx_t x1_r;
    geom_pkg::sx_t x2_r;
    geom_pkg::sx_t x3_r;
    geom_pkg::sy_t y12_r;
    geom_pkg::sy_t y3_r;
    geom_pkg::sx_t radius_r;

    // Active circle and arc filter
    geom_pkg::sx_t sel_cx;
    geom_pkg::sy_t sel_cy;
    geom_pkg::sx_t arc_x;
    geom_pkg::sy_t arc_y;
    logic          arc_ok;

    reuleaux_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .fill_done    (fill_done),
        .circle_done  (circle_done),
        .done         (done),
        .fill_start   (fill_start),
        .load_corners (load_corners),
        .circle_start (circle_start),
        .draw_arcs    (draw_arcs),
        .arc_sel      (arc_sel)
    );

    fillscreen #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H)
    ) u_fillscreen (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (fill_start),
        .done     (fill_done),
        .vga_x    (fill_x),
        .vga_y    (fill_y),
        .vga_plot (fill_plot)
    );

    // Centre and diameter are unsigned on the port
    assign cx_s   = {1'b0, centre_x};
    assign cy_s   = {1'b0, centre_y};
    assign d_s    = {1'b0, diameter};
    assign half_d = d_s >>> 1;

    assign prod_side = geom_pkg::prod_t'(d_s) * geom_pkg::prod_t'(geom_pkg::SQRT3_DIV6);
    assign prod_top  = geom_pkg::prod_t'(d_s) * geom_pkg::prod_t'(geom_pkg::SQRT3_DIV3);

    assign x1_c  = cx_s + half_d;
    assign x2_c  = cx_s - half_d;
    assign x3_c  = cx_s;
    assign y12_c = cy_s + geom_pkg::sy_t'(prod_side >>> geom_pkg::FRAC_BITS);
    assign y3_c  = cy_s - geom_pkg::sy_t'(prod_top >>> geom_pkg::FRAC_BITS);

    always_ff @(posedge clk) begin
        if (load_corners) begin
            x1_r     <= x1_c;
            x2_r     <= x2_c;
            x3_r     <= x3_c;
            y12_r    <= y12_c;
            y3_r     <= y3_c;
            radius_r <= d_s;
        end
    end

    always_comb begin
        case (arc_sel)
            2'd0:    begin sel_cx = x1_r; sel_cy = y12_r; end
            2'd1:    begin sel_cx = x2_r; sel_cy = y12_r; end
            default: begin sel_cx = x3_r; sel_cy = y3_r;  end
        endcase
    end

    circle #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H)
    ) u_circle (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (circle_start),
        .centre_x (sel_cx),
        .centre_y (sel_cy),
        .radius   (radius_r),
        .done     (circle_done),
        .vga_x    (circ_x),
        .vga_y    (circ_y),
        .vga_plot (circ_plot)
    );

    assign arc_x = {1'b0, circ_x};
    assign arc_y = {1'b0, circ_y};

    // Each circle keeps only the arc facing the opposite side
    always_comb begin
        case (arc_sel)
            2'd0:    arc_ok = (arc_x >= x2_r) && (arc_x <= x3_r) && (arc_y <= y12_r);
            2'd1:    arc_ok = (arc_x >= x3_r) && (arc_x <= x1_r) && (arc_y <= y12_r);
            default: arc_ok = (arc_x >= x2_r) && (arc_x <= x1_r) && (arc_y >= y12_r);
        endcase
    end

    assign vga_x      = draw_arcs ? circ_x : fill_x;
    assign vga_y      = draw_arcs ? circ_y : fill_y;
    assign vga_plot   = draw_arcs ? (circ_plot && arc_ok) : fill_plot;
    assign vga_colour = draw_arcs ? colour : vga_pkg::COLOUR_BLACK;

    // Only one pixel source may be active at a time
    a_one_source: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(fill_plot && circ_plot)
    );

endmodule

// File: reuleaux/reuleaux_fsm.sv
`timescale 1ns/1ps

// Clear, corner load and three arc passes in order
module reuleaux_fsm (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic       fill_done,
    input  logic       circle_done,
    output logic       done,
    output logic       fill_start,
    output logic       load_corners,
    output logic       circle_start,
    output logic       draw_arcs,
    output logic [1:0] arc_sel
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_CLEAR,
        S_LOAD,
        S_ARC1,
        S_ARC1_GAP,
        S_ARC2,
        S_ARC2_GAP,
        S_ARC3,
        S_FINISHED
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else if (!start) begin
            // Dropping start abandons any pass and releases done
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:     state <= S_CLEAR;
                S_CLEAR:    if (fill_done) state <= S_LOAD;
                S_LOAD:     state <= S_ARC1;
                S_ARC1:     if (circle_done) state <= S_ARC1_GAP;
                S_ARC1_GAP: state <= S_ARC2;
                S_ARC2:     if (circle_done) state <= S_ARC2_GAP;
                S_ARC2_GAP: state <= S_ARC3;
                S_ARC3:     if (circle_done) state <= S_FINISHED;
                default:    state <= S_FINISHED;
            endcase
        end
    end

    assign done         = (state == S_FINISHED);
    assign fill_start   = (state == S_CLEAR);
    assign load_corners = (state == S_LOAD);
    assign circle_start = (state == S_ARC1) || (state == S_ARC2) || (state == S_ARC3);

    // Gap states count as arc time so the mux holds the circle path
    assign draw_arcs = (state == S_ARC1) || (state == S_ARC1_GAP) ||
                       (state == S_ARC2) || (state == S_ARC2_GAP) ||
                       (state == S_ARC3);

    always_comb begin
        case (state)
            S_ARC2, S_ARC2_GAP: arc_sel = 2'd1;
            S_ARC3:             arc_sel = 2'd2;
            default:            arc_sel = 2'd0;
        endcase
    end

    a_load_not_with_circle: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load_corners && circle_start)
    );

endmodule

// File: circle/circle.sv
`timescale 1ns/1ps

// Midpoint circle rasteriser, one octant point per cycle
module circle #(
    parameter int SCREEN_W = 160,
    parameter int SCREEN_H = 120
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    input  geom_pkg::sx_t centre_x,
    input  geom_pkg::sy_t centre_y,
    input  geom_pkg::sx_t radius,
    output logic          done,
    output vga_pkg::x_t   vga_x,
    output vga_pkg::y_t   vga_y,
    output logic          vga_plot
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_OCT1,
        S_OCT2,
        S_OCT3,
        S_OCT4,
        S_OCT5,
        S_OCT6,
        S_OCT7,
        S_OCT8,
        S_STEP,
        S_DONE
    } state_t;

    state_t state;

    geom_pkg::sx_t      offset_x;
    geom_pkg::sx_t      offset_y;
    logic signed [10:0] crit;

    // Values after one midpoint step
    geom_pkg::sx_t      step_ox;
    geom_pkg::sx_t      step_oy;
    logic signed [10:0] step_crit;

    // Current point, wide enough for centre plus radius either way
    logic signed [9:0] cx_w;
    logic signed [9:0] cy_w;
    logic signed [9:0] ox_w;
    logic signed [9:0] oy_w;
    logic signed [9:0] pt_x;
    logic signed [9:0] pt_y;
    logic              in_octant;
    logic              on_screen;

    always_comb begin
        step_oy = offset_y + 1;
        if (crit <= 0) begin
            step_ox   = offset_x;
            step_crit = crit + 2 * step_oy + 1;
        end else begin
            step_ox   = offset_x - 1;
            step_crit = crit + 2 * (step_oy - step_ox) + 1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else if (!start) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: state <= S_OCT1;
                S_OCT1: state <= S_OCT2;
                S_OCT2: state <= S_OCT3;
                S_OCT3: state <= S_OCT4;
                S_OCT4: state <= S_OCT5;
                S_OCT5: state <= S_OCT6;
                S_OCT6: state <= S_OCT7;
                S_OCT7: state <= S_OCT8;
                S_OCT8: state <= S_STEP;
                S_STEP: state <= (step_oy <= step_ox) ? S_OCT1 : S_DONE;
                default: state <= S_DONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            offset_x <= radius;
            offset_y <= '0;
            crit     <= 1 - radius;
        end else if (state == S_STEP) begin
            offset_x <= step_ox;
            offset_y <= step_oy;
            crit     <= step_crit;
        end
    end

    assign cx_w = {centre_x[8], centre_x};
    assign cy_w = {{2{centre_y[7]}}, centre_y};
    assign ox_w = {offset_x[8], offset_x};
    assign oy_w = {offset_y[8], offset_y};

    always_comb begin
        in_octant = 1'b1;
        case (state)
            S_OCT1: begin pt_x = cx_w + ox_w; pt_y = cy_w + oy_w; end
            S_OCT2: begin pt_x = cx_w + oy_w; pt_y = cy_w + ox_w; end
            S_OCT3: begin pt_x = cx_w - ox_w; pt_y = cy_w + oy_w; end
            S_OCT4: begin pt_x = cx_w - oy_w; pt_y = cy_w + ox_w; end
            S_OCT5: begin pt_x = cx_w - ox_w; pt_y = cy_w - oy_w; end
            S_OCT6: begin pt_x = cx_w - oy_w; pt_y = cy_w - ox_w; end
            S_OCT7: begin pt_x = cx_w + ox_w; pt_y = cy_w - oy_w; end
            S_OCT8: begin pt_x = cx_w + oy_w; pt_y = cy_w - ox_w; end
            default: begin
                pt_x      = cx_w;
                pt_y      = cy_w;
                in_octant = 1'b0;
            end
        endcase
    end

    // Off-screen points are dropped here
    assign on_screen = (pt_x >= 0) && (pt_x < SCREEN_W) && (pt_y >= 0) && (pt_y < SCREEN_H);

    assign vga_plot = in_octant && on_screen;
    assign vga_x    = pt_x[7:0];
    assign vga_y    = pt_y[6:0];
    assign done     = (state == S_DONE);

    a_plot_on_screen: assert property (
        @(posedge clk) disable iff (!rst_n)
        vga_plot |-> (vga_x < SCREEN_W) && (vga_y < SCREEN_H)
    );

endmodule

// File: verilog/fillscreen.sv
`timescale 1ns/1ps

// Column-major sweep over the whole screen at one pixel per cycle
module fillscreen #(
    parameter int SCREEN_W = 160,
    parameter int SCREEN_H = 120
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    output logic        done,
    output vga_pkg::x_t vga_x,
    output vga_pkg::y_t vga_y,
    output logic        vga_plot
);

    localparam vga_pkg::x_t LAST_X = vga_pkg::x_t'(SCREEN_W - 1);
    localparam vga_pkg::y_t LAST_Y = vga_pkg::y_t'(SCREEN_H - 1);

    vga_pkg::x_t x_cnt;
    vga_pkg::y_t y_cnt;
    logic        done_r;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x_cnt  <= '0;
            y_cnt  <= '0;
            done_r <= 1'b0;
        end else if (!start) begin
            // Rearm for the next request
            x_cnt  <= '0;
            y_cnt  <= '0;
            done_r <= 1'b0;
        end else if (!done_r) begin
            if (y_cnt == LAST_Y) begin
                y_cnt <= '0;
                if (x_cnt == LAST_X) begin
                    x_cnt  <= '0;
                    done_r <= 1'b1;
                end else begin
                    x_cnt <= x_cnt + 1'b1;
                end
            end else begin
                y_cnt <= y_cnt + 1'b1;
            end
        end
    end

    // Plot in every cycle of the sweep until the last pixel is out
    assign vga_plot = start && !done_r;
    assign vga_x    = x_cnt;
    assign vga_y    = y_cnt;
    assign done     = done_r;

    a_plot_on_screen: assert property (
        @(posedge clk) disable iff (!rst_n)
        vga_plot |-> (vga_x < SCREEN_W) && (vga_y < SCREEN_H)
    );

endmodule

// File: common/geom_pkg.sv
package geom_pkg;

    // Signed coordinates for corners and circle points that may leave the screen
    typedef logic signed [8:0] sx_t;
    typedef logic signed [7:0] sy_t;

    // Fraction bits of the fixed-point constants
    localparam int FRAC_BITS = 12;

    // sqrt(3)/6 and sqrt(3)/3 scaled by 2**FRAC_BITS
    localparam int SQRT3_DIV6 = 1182;
    localparam int SQRT3_DIV3 = 2365;

    // Diameter times a constant before the fraction is dropped
    typedef logic signed [FRAC_BITS+8:0] prod_t;

endpackage

// File: common/vga_pkg.sv
package vga_pkg;

    // Screen column, wide enough for any column of a 160 pixel line
    typedef logic [7:0] x_t;

    // Screen row
    typedef logic [6:0] y_t;

    // 3-bit RGB pixel colour
    typedef logic [2:0] colour_t;

    // Colour written by the clear pass
    localparam colour_t COLOUR_BLACK = 3'b000;

endpackage
